//--- verilog/x86_decode_pkg.sv
package x86_decode_pkg;

    // longest legal x86 instruction
    localparam int max_instr_bytes = 15;
    localparam int instr_width     = max_instr_bytes * 8;

    // displacement and immediate sizes in bytes
    localparam int disp8_bytes  = 1;
    localparam int disp32_bytes = 4;
    localparam int imm8_bytes   = 1;
    localparam int imm32_bytes  = 4;

    // modr/m mod field
    localparam logic [1:0] mod_indir  = 2'b00;
    localparam logic [1:0] mod_disp8  = 2'b01;
    localparam logic [1:0] mod_disp32 = 2'b10;
    localparam logic [1:0] mod_direct = 2'b11;

    // modr/m r/m escapes
    localparam logic [2:0] rm_sib = 3'b100;
    localparam logic [2:0] rm_abs = 3'b101;

    typedef logic [3:0] len_t;

    // byte 0 sits in bits 7:0
    typedef struct packed {
        logic [instr_width-1:0] bytes;
        len_t                   len;
    } instr_t;

    // alu ops first so bits 5:3 of the opcode map straight across
    typedef enum logic [3:0] {
        OPC_ADD     = 4'h0,
        OPC_OR      = 4'h1,
        OPC_ADC     = 4'h2,
        OPC_SBB     = 4'h3,
        OPC_AND     = 4'h4,
        OPC_SUB     = 4'h5,
        OPC_XOR     = 4'h6,
        OPC_CMP     = 4'h7,
        OPC_PUSH    = 4'h8,
        OPC_POP     = 4'h9,
        OPC_INVALID = 4'hA,
        OPC_DAA     = 4'hC,
        OPC_DAS     = 4'hD,
        OPC_AAA     = 4'hE,
        OPC_AAS     = 4'hF
    } opc_e;

    // general regs in modr/m order, segment regs above
    typedef enum logic [3:0] {
        REG_EAX = 4'h0,
        REG_ECX = 4'h1,
        REG_EDX = 4'h2,
        REG_EBX = 4'h3,
        REG_ESP = 4'h4,
        REG_EBP = 4'h5,
        REG_ESI = 4'h6,
        REG_EDI = 4'h7,
        REG_ES  = 4'h8,
        REG_CS  = 4'h9,
        REG_SS  = 4'hA,
        REG_DS  = 4'hB
    } reg_e;

    typedef struct packed {
        logic val;
        logic is_reg;
        logic mem;
        logic off;
        logic imm;
    } opnd_flags_t;

    // data carries displacement or immediate
    typedef struct packed {
        opnd_flags_t flags;
        reg_e        rg;
        logic [31:0] data;
    } operand_t;

    typedef struct packed {
        opc_e     opc;
        operand_t dst;
        operand_t src;
        len_t     len;
    } decoded_t;

    // accumulator operand and immediate template for the acc-imm forms
    localparam operand_t eax_operand = '{flags: 5'b11000, rg: REG_EAX, data: 32'h0};
    localparam operand_t imm_operand = '{flags: 5'b10001, rg: REG_EAX, data: 32'h0};

endpackage

//--- verilog/byte_stream_if.sv
`timescale 1ns/1ps

// instruction bytes from feeder to decoder, one per take
interface byte_stream_if;

    // current byte present
    logic       valid;
    logic [7:0] data;
    // byte index is len minus one
    logic       last;

    // consumes data when valid
    logic       take;
    // result handed on, flush whatever is left
    logic       done;

    modport feeder (
        output valid,
        output data,
        output last,
        input  take,
        input  done
    );

    modport decoder (
        input  valid,
        input  data,
        input  last,
        output take,
        output done
    );

endinterface

//--- verilog/hold_stage.sv
`timescale 1ns/1ps

// single entry valid/ready register slice
module hold_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     i_arst_n,

    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,

    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     full;
    payload_t data_q;

    // free when empty or draining this cycle
    assign o_ready = !full || i_ready;
    assign o_valid = full;
    assign o_data  = data_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            full <= 1'b0;
        end else if (o_ready) begin
            full <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            data_q <= i_data;
        end
    end

    // a refused offer stays up and unchanged until it is taken
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_valid && !o_ready) |=> (i_valid && $stable(i_data))
    );

endmodule

//--- verilog/instr_byte_feeder.sv
`timescale 1ns/1ps

// holds one instruction, shows it a byte at a time
module instr_byte_feeder
    import x86_decode_pkg::*;
(
    input  logic          clk,
    input  logic          i_arst_n,

    input  logic          i_valid,
    output logic          o_ready,
    input  instr_t        i_instr,

    byte_stream_if.feeder bs
);

    logic [instr_width-1:0] shift_q;
    len_t                   left_q;
    logic                   busy;
    logic                   load;

    // free again on the done cycle itself
    assign o_ready = !busy || bs.done;
    assign load    = i_valid && o_ready;

    // bytes run out before done arrives
    assign bs.valid = busy && (left_q != '0);
    assign bs.data  = shift_q[7:0];
    assign bs.last  = (left_q == len_t'(1));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy   <= 1'b0;
            left_q <= '0;
        end else if (load) begin
            busy   <= 1'b1;
            // zero length shows byte 0 as the only byte
            left_q <= (i_instr.len == '0) ? len_t'(1) : i_instr.len;
        end else if (bs.done) begin
            // drop any unread tail
            busy   <= 1'b0;
            left_q <= '0;
        end else if (bs.take) begin
            left_q <= left_q - len_t'(1);
        end
    end

    // low byte always at the front
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= i_instr.bytes;
        end else if (bs.take) begin
            shift_q <= shift_q >> 8;
        end
    end

    // decoder only consumes bytes that are actually there
    a_take_needs_valid: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        bs.take |-> bs.valid
    );

endmodule

//--- verilog/operand_decoder.sv
`timescale 1ns/1ps

// byte serial decode of the 00h..3fh opcode block
module operand_decoder
    import x86_decode_pkg::*;
(
    input  logic           clk,
    input  logic           i_arst_n,

    byte_stream_if.decoder bs,

    output logic           o_valid,
    input  logic           i_ready,
    output decoded_t       o_result
);

    typedef enum logic [2:0] {
        S_OPC,
        S_MODRM,
        S_DISP,
        S_IMM,
        S_FIN
    } state_e;

    state_e      state;
    state_e      nxt_state;
    opc_e        opc_q;
    operand_t    dst_q;
    operand_t    src_q;
    len_t        cnt_q;
    logic        dir_q;
    logic [2:0]  fld_cnt;
    logic [2:0]  fld_len;
    logic [31:0] acc;
    logic [31:0] nxt_acc;
    logic        fld_end;
    logic        bad;
    logic        tail;
    logic [7:0]  b;
    logic [1:0]  mrm_mod;
    logic [2:0]  mrm_rm;
    logic        mrm_abs;
    operand_t    reg_opnd;
    operand_t    rm_opnd;
    operand_t    seg_opnd;

    assign b       = bs.data;
    assign mrm_mod = b[7:6];
    assign mrm_rm  = b[2:0];
    // mod 00 r/m 101 is disp32 with no base
    assign mrm_abs = (mrm_mod == mod_indir) && (mrm_rm == rm_abs);

    assign bs.take  = bs.valid && (state != S_FIN);
    assign o_valid  = (state == S_FIN);
    assign bs.done  = o_valid && i_ready;
    assign o_result = '{opc: opc_q, dst: dst_q, src: src_q, len: cnt_q};

    always_comb begin
        fld_end = (fld_cnt == fld_len - 3'd1);
        // little endian assembly, sign extended as it grows
        case (fld_cnt)
            3'd0:    nxt_acc = {{24{b[7]}}, b};
            3'd1:    nxt_acc = {{16{b[7]}}, b, acc[7:0]};
            3'd2:    nxt_acc = {{8{b[7]}}, b, acc[15:0]};
            default: nxt_acc = {b, acc[23:0]};
        endcase

        // modr/m reg field, always a plain register
        reg_opnd = '{flags: 5'b11000, rg: reg_e'({1'b0, b[5:3]}), data: 32'h0};
        // modr/m r/m field
        rm_opnd.flags.val    = 1'b1;
        rm_opnd.flags.is_reg = !mrm_abs;
        rm_opnd.flags.mem    = (mrm_mod != mod_direct);
        rm_opnd.flags.off    = (mrm_mod == mod_disp8) || (mrm_mod == mod_disp32) || mrm_abs;
        rm_opnd.flags.imm    = 1'b0;
        rm_opnd.rg           = mrm_abs ? REG_EAX : reg_e'({1'b0, mrm_rm});
        rm_opnd.data         = 32'h0;
        // es cs ss ds from bits 4:3
        seg_opnd = '{flags: 5'b11000, rg: reg_e'({2'b10, b[4:3]}), data: 32'h0};

        bad       = 1'b0;
        nxt_state = state;
        case (state)
            S_OPC: begin
                // 26 2e 36 3e are segment prefixes, 0f escapes to two bytes
                if (b[7:6] != 2'b00 || (b[5] && b[2:0] == 3'b110) || b == 8'h0F) begin
                    bad       = 1'b1;
                    nxt_state = S_FIN;
                end else if (b[2:1] == 2'b11) begin
                    nxt_state = S_FIN;
                end else if (b[2]) begin
                    nxt_state = S_IMM;
                end else begin
                    nxt_state = S_MODRM;
                end
            end
            S_MODRM: begin
                if (mrm_rm == rm_sib && mrm_mod != mod_direct) begin
                    // sib form not handled
                    bad       = 1'b1;
                    nxt_state = S_FIN;
                end else if (rm_opnd.flags.off) begin
                    nxt_state = S_DISP;
                end else begin
                    nxt_state = S_FIN;
                end
            end
            S_DISP, S_IMM: nxt_state = fld_end ? S_FIN : state;
            default:       nxt_state = i_ready ? S_OPC : S_FIN;
        endcase

        // stream ended with the encoding still open
        if (bs.take && bs.last && nxt_state != S_FIN) begin
            bad       = 1'b1;
            nxt_state = S_FIN;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= S_OPC;
            cnt_q   <= '0;
            fld_cnt <= '0;
            tail    <= 1'b0;
        end else begin
            if (bs.take || o_valid) begin
                state <= nxt_state;
            end
            if (bs.take) begin
                // consumed length restarts at the opcode
                cnt_q   <= (state == S_OPC) ? len_t'(1) : cnt_q + len_t'(1);
                fld_cnt <= (state == S_DISP || state == S_IMM) ? fld_cnt + 3'd1 : 3'd0;
            end
            if (bs.take && bs.last) begin
                tail <= 1'b1;
            end else if (bs.done) begin
                tail <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bs.take) begin
            case (state)
                S_OPC: begin
                    dir_q   <= b[1];
                    // odd opcodes carry a full dword
                    fld_len <= b[0] ? 3'(imm32_bytes) : 3'(imm8_bytes);
                    opc_q   <= opc_e'({1'b0, b[5:3]});
                    dst_q   <= '0;
                    src_q   <= '0;
                    if (b[2:1] == 2'b11 && !b[5]) begin
                        opc_q <= opc_e'({3'b100, b[0]});
                        dst_q <= seg_opnd;
                    end else if (b[2:1] == 2'b11) begin
                        // daa das aaa aas
                        opc_q <= opc_e'({2'b11, b[4:3]});
                    end else if (b[2]) begin
                        dst_q <= eax_operand;
                        src_q <= imm_operand;
                    end
                end
                S_MODRM: begin
                    fld_len <= (mrm_mod == mod_disp8) ? 3'(disp8_bytes) : 3'(disp32_bytes);
                    // direction bit set, reg field is the destination
                    dst_q   <= dir_q ? reg_opnd : rm_opnd;
                    src_q   <= dir_q ? rm_opnd : reg_opnd;
                end
                S_DISP: begin
                    acc <= nxt_acc;
                    if (fld_end && dir_q) begin
                        src_q.data <= nxt_acc;
                    end else if (fld_end) begin
                        dst_q.data <= nxt_acc;
                    end
                end
                S_IMM: begin
                    acc <= nxt_acc;
                    if (fld_end) begin
                        src_q.data <= nxt_acc;
                    end
                end
                default: begin
                    acc <= acc;
                end
            endcase
            if (bad) begin
                opc_q <= OPC_INVALID;
                dst_q <= '0;
                src_q <= '0;
            end
        end
    end

    // feeder offers nothing past the final byte and nothing is pulled until the result leaves
    a_no_take_after_last: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        tail |-> !(bs.valid || bs.take)
    );

endmodule

//--- verilog/x86_decoder.sv
`timescale 1ns/1ps

// instruction in, decoded result out, three entries deep at most
module x86_decoder
    import x86_decode_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_arst_n,

    input  logic                   i_instr_valid,
    output logic                   o_instr_ready,
    input  logic [instr_width-1:0] i_instr,
    input  len_t                   i_instr_len,

    output logic                   o_res_valid,
    input  logic                   i_res_ready,
    output opc_e                   o_res_opcode,
    output operand_t               o_res_dst,
    output operand_t               o_res_src,
    output len_t                   o_res_len
);

    instr_t   in_data;
    instr_t   hold_data;
    logic     hold_valid;
    logic     hold_ready;
    decoded_t dec_result;
    logic     dec_valid;
    logic     dec_ready;
    decoded_t res_data;

    byte_stream_if bs_if ();

    assign in_data = '{bytes: i_instr, len: i_instr_len};

    // fetch side slice
    hold_stage #(.payload_t(instr_t)) in_hold (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_instr_valid),
        .o_ready  (o_instr_ready),
        .i_data   (in_data),
        .o_valid  (hold_valid),
        .i_ready  (hold_ready),
        .o_data   (hold_data)
    );

    instr_byte_feeder feeder_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (hold_valid),
        .o_ready  (hold_ready),
        .i_instr  (hold_data),
        .bs       (bs_if)
    );

    operand_decoder dec_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .bs       (bs_if),
        .o_valid  (dec_valid),
        .i_ready  (dec_ready),
        .o_result (dec_result)
    );

    // execute side slice
    hold_stage #(.payload_t(decoded_t)) out_hold (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (dec_valid),
        .o_ready  (dec_ready),
        .i_data   (dec_result),
        .o_valid  (o_res_valid),
        .i_ready  (i_res_ready),
        .o_data   (res_data)
    );

    assign o_res_opcode = res_data.opc;
    assign o_res_dst    = res_data.dst;
    assign o_res_src    = res_data.src;
    assign o_res_len    = res_data.len;

endmodule

//--- sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// instruction families for the generator
localparam int fam_regdir = 0;
localparam int fam_accimm = 1;
localparam int fam_mem    = 2;
localparam int fam_segbcd = 3;
localparam int fam_bad    = 4;

localparam logic [31:0] lfsr_seed = 32'haa1ce54f;
// taps 32 22 2 1, right shifting form
localparam logic [31:0] lfsr_taps = 32'h80200003;

logic [31:0] lfsr_state = lfsr_seed;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
endfunction

// one lfsr step per bit, lsb first
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r[i] = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
endfunction

function automatic decoded_t invalid_ref(input int n);
    decoded_t r;
    r = '0;
    r.opc = OPC_INVALID;
    r.len = len_t'(n);
    return r;
endfunction

// plain register operand
function automatic operand_t reg_ref(input reg_e rg);
    operand_t o;
    o = '0;
    o.flags.val    = 1'b1;
    o.flags.is_reg = 1'b1;
    o.rg           = rg;
    return o;
endfunction

// x86 alu order of opcode bits 5:3
function automatic opc_e alu_ref(input logic [2:0] f);
    case (f)
        3'd0:    return OPC_ADD;
        3'd1:    return OPC_OR;
        3'd2:    return OPC_ADC;
        3'd3:    return OPC_SBB;
        3'd4:    return OPC_AND;
        3'd5:    return OPC_SUB;
        3'd6:    return OPC_XOR;
        default: return OPC_CMP;
    endcase
endfunction

function automatic decoded_t decode_ref(input instr_t t);
    decoded_t    r;
    operand_t    rm_o;
    logic [7:0]  op;
    logic [7:0]  mrm;
    logic        abs_form;
    int          n;
    int          dsz;
    op  = t.bytes[7:0];
    mrm = t.bytes[15:8];
    // zero length still shows byte 0
    n   = (t.len == '0) ? 1 : int'(t.len);
    r   = '0;
    r.len = len_t'(1);
    // outside the block, segment prefixes, two byte escape
    if (op > 8'h3f || op == 8'h0f || (op[5] && op[2:0] == 3'b110)) begin
        return invalid_ref(1);
    end
    // push/pop es cs ss ds
    if (op < 8'h20 && op[2:1] == 2'b11) begin
        r.opc = op[0] ? OPC_POP : OPC_PUSH;
        case (op[4:3])
            2'd0:    r.dst = reg_ref(REG_ES);
            2'd1:    r.dst = reg_ref(REG_CS);
            2'd2:    r.dst = reg_ref(REG_SS);
            default: r.dst = reg_ref(REG_DS);
        endcase
        return r;
    end
    // bcd adjust, no operands
    if (op[2:0] == 3'b111) begin
        case (op)
            8'h27:   r.opc = OPC_DAA;
            8'h2f:   r.opc = OPC_DAS;
            8'h37:   r.opc = OPC_AAA;
            default: r.opc = OPC_AAS;
        endcase
        return r;
    end
    r.opc = alu_ref(op[5:3]);
    // accumulator with imm8 or imm32
    if (op[2]) begin
        dsz = op[0] ? 4 : 1;
        if (n < 1 + dsz) begin
            return invalid_ref(n);
        end
        r.dst = reg_ref(REG_EAX);
        r.src.flags.val = 1'b1;
        r.src.flags.imm = 1'b1;
        r.src.data = op[0] ? t.bytes[39:8] : {{24{t.bytes[15]}}, t.bytes[15:8]};
        r.len = len_t'(1 + dsz);
        return r;
    end
    if (n < 2) begin
        return invalid_ref(n);
    end
    // sib byte not supported
    if (mrm[7:6] != 2'b11 && mrm[2:0] == 3'b100) begin
        return invalid_ref(2);
    end
    abs_form = (mrm[7:6] == 2'b00 && mrm[2:0] == 3'b101);
    if (mrm[7:6] == 2'b01) begin
        dsz = 1;
    end else if (mrm[7:6] == 2'b10 || abs_form) begin
        dsz = 4;
    end else begin
        dsz = 0;
    end
    if (n < 2 + dsz) begin
        return invalid_ref(n);
    end
    rm_o = '0;
    rm_o.flags.val    = 1'b1;
    rm_o.flags.is_reg = !abs_form;
    rm_o.flags.mem    = (mrm[7:6] != 2'b11);
    rm_o.flags.off    = (dsz != 0);
    rm_o.rg           = abs_form ? REG_EAX : reg_e'({1'b0, mrm[2:0]});
    if (dsz == 1) begin
        rm_o.data = {{24{t.bytes[23]}}, t.bytes[23:16]};
    end else if (dsz == 4) begin
        rm_o.data = t.bytes[47:16];
    end
    // direction bit set means reg field is dst
    r.dst = op[1] ? reg_ref(reg_e'({1'b0, mrm[5:3]})) : rm_o;
    r.src = op[1] ? rm_o : reg_ref(reg_e'({1'b0, mrm[5:3]}));
    r.len = len_t'(2 + dsz);
    return r;
endfunction

// random filler behind the first two bytes
function automatic instr_t build_instr(input logic [7:0] b0, input logic [7:0] b1,
                                       input int n);
    instr_t t;
    for (int i = 0; i < max_instr_bytes; i++) begin
        t.bytes[i*8 +: 8] = 8'(rand_bits(8));
    end
    t.bytes[7:0]  = b0;
    t.bytes[15:8] = b1;
    t.len         = len_t'(n);
    return t;
endfunction

function automatic logic [7:0] seg_bcd_op(input int k);
    case (k)
        0:       return 8'h06;
        1:       return 8'h07;
        2:       return 8'h0e;
        3:       return 8'h16;
        4:       return 8'h17;
        5:       return 8'h1e;
        6:       return 8'h1f;
        7:       return 8'h27;
        8:       return 8'h2f;
        9:       return 8'h37;
        default: return 8'h3f;
    endcase
endfunction

function automatic instr_t gen_instr(input int fam);
    logic [7:0] op;
    logic [1:0] md;
    logic [2:0] rm;
    int         sel;
    int         nat;
    // modr/m form by default, alu field random
    op  = {2'b00, 3'(rand_bits(3)), 1'b0, 2'(rand_bits(2))};
    sel = int'(rand_bits(2));
    rm  = 3'(rand_bits(3));
    case (fam)
        fam_regdir: return build_instr(op, {2'b11, 6'(rand_bits(6))}, 2);
        fam_accimm: begin
            op = {op[7:3], 2'b10, op[0]};
            return build_instr(op, 8'(rand_bits(8)), op[0] ? 5 : 2);
        end
        fam_mem: begin
            // keep clear of sib, abs only on purpose
            case (sel)
                0: begin
                    md  = 2'b00;
                    rm  = (rm == 3'd4 || rm == 3'd5) ? (rm ^ 3'b010) : rm;
                    nat = 2;
                end
                1: begin
                    md  = 2'b01;
                    rm  = (rm == 3'd4) ? 3'd5 : rm;
                    nat = 3;
                end
                2: begin
                    md  = 2'b10;
                    rm  = (rm == 3'd4) ? 3'd5 : rm;
                    nat = 6;
                end
                default: begin
                    md  = 2'b00;
                    rm  = 3'd5;
                    nat = 6;
                end
            endcase
            return build_instr(op, {md, 3'(rand_bits(3)), rm}, nat);
        end
        fam_segbcd: begin
            return build_instr(seg_bcd_op(int'(rand_bits(4) % 11)), 8'(rand_bits(8)), 1);
        end
        default: begin
            case (sel)
                0: begin
                    // prefix or 0f escape
                    op = (rand_bits(3) == 0) ? 8'h0f : {3'b001, 2'(rand_bits(2)), 3'b110};
                    return build_instr(op, 8'(rand_bits(8)), 1 + int'(rand_bits(3)));
                end
                1: begin
                    op = 8'(rand_bits(8));
                    op = (op < 8'h40) ? op + 8'h40 : op;
                    return build_instr(op, 8'(rand_bits(8)), 1 + int'(rand_bits(3)));
                end
                2: begin
                    md = 2'(rand_bits(2));
                    md = (md == 2'b11) ? 2'b00 : md;
                    return build_instr(op, {md, 3'(rand_bits(3)), 3'b100},
                                       2 + int'(rand_bits(3)));
                end
                default: begin
                    // imm32 or disp32 cut short
                    if (rand_bits(1) != 0) begin
                        op  = {op[7:3], 3'b101};
                        nat = 5;
                    end else begin
                        nat = 6;
                    end
                    return build_instr(op, {2'b10, 3'(rand_bits(3)), 3'b000},
                                       1 + int'(rand_bits(3)) % (nat - 1));
                end
            endcase
        end
    endcase
endfunction

`endif

//--- sim/tb_x86_decoder.sv
`timescale 1ns/1ps

module tb_x86_decoder
    import x86_decode_pkg::*;
();

    localparam int timeout_cycles = 2000;
    localparam int n_mem          = 40;
    localparam int n_bad          = 40;
    localparam int n_random       = 300;

    logic                   clk;
    logic                   i_arst_n;
    logic                   i_instr_valid;
    logic                   o_instr_ready;
    logic [instr_width-1:0] i_instr;
    len_t                   i_instr_len;
    logic                   o_res_valid;
    logic                   i_res_ready;
    opc_e                   o_res_opcode;
    operand_t               o_res_dst;
    operand_t               o_res_src;
    len_t                   o_res_len;

    // expected results in issue order
    decoded_t exp_q[$];
    int       errors;
    int       checks;
    int       tests_run;
    int       tests_failed;
    logic     stall_mode;

    `include "tb_ref_model.svh"

    x86_decoder dut_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .i_instr       (i_instr),
        .i_instr_len   (i_instr_len),
        .o_res_valid   (o_res_valid),
        .i_res_ready   (i_res_ready),
        .o_res_opcode  (o_res_opcode),
        .o_res_dst     (o_res_dst),
        .o_res_src     (o_res_src),
        .o_res_len     (o_res_len)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $finish;
    endtask

    task automatic check_decoded(input decoded_t got, input decoded_t want);
        checks++;
        if (got.opc !== want.opc || got.dst !== want.dst || got.src !== want.src) begin
            errors++;
            $display("error at %0t ns: got %s dst %h src %h, expected %s dst %h src %h",
                     $time, got.opc.name(), got.dst, got.src,
                     want.opc.name(), want.dst, want.src);
        end
    endtask

    task automatic check_len(input len_t got, input len_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t ns: length %0d, expected %0d", $time, got, want);
        end
    endtask

    // sampled mid cycle, the transfer itself happens on the next rising edge
    always @(negedge clk) begin
        decoded_t got;
        decoded_t want;
        if (i_arst_n && o_res_valid && i_res_ready) begin
            got = '{opc: o_res_opcode, dst: o_res_dst, src: o_res_src, len: o_res_len};
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at %0t ns: result with nothing outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                check_decoded(got, want);
                check_len(got.len, want.len);
            end
        end
    end

    // back-pressure, drawn mid cycle and driven after the edge
    always begin
        logic pick;
        @(negedge clk);
        pick = stall_mode ? (rand_bits(1) != 0) : 1'b1;
        @(posedge clk);
        #2;
        i_res_ready = pick;
    end

    // called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic send_instr(input instr_t t);
        int waited;
        waited        = 0;
        i_instr_valid = 1'b1;
        i_instr       = t.bytes;
        i_instr_len   = t.len;
        @(negedge clk);
        while (!o_instr_ready) begin
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout: the decoder never accepted an instruction");
            end
            @(negedge clk);
        end
        exp_q.push_back(decode_ref(t));
        @(posedge clk);
        #2;
        i_instr_valid = 1'b0;
    endtask

    // wait for every outstanding result, then report the test
    task automatic end_test(input string name, input int errs_before);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > timeout_cycles) begin
                abort_run({"timeout: results missing at the end of test ", name});
            end
            @(posedge clk);
        end
        @(posedge clk);
        #2;
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e0;
        clk           = 1'b0;
        i_arst_n      = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_instr_len   = '0;
        i_res_ready   = 1'b1;
        stall_mode    = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (16) @(posedge clk);
        #2;
        i_arst_n = 1'b1;

        // idle outputs straight after reset
        e0 = errors;
        @(negedge clk);
        checks += 2;
        if (o_res_valid !== 1'b0 || o_instr_ready !== 1'b1) begin
            errors++;
            $display("error at %0t ns: res_valid %b instr_ready %b after reset",
                     $time, o_res_valid, o_instr_ready);
        end
        @(posedge clk);
        #2;
        end_test("reset_state", e0);

        // every alu op in all four modr/m forms, then acc-imm
        e0 = errors;
        for (int k = 0; k < 32; k++) begin
            send_instr(build_instr({2'b00, 3'(k >> 2), 1'b0, 2'(k)},
                                   {2'b11, 6'(rand_bits(6))}, 2));
        end
        for (int k = 0; k < 16; k++) begin
            send_instr(build_instr({2'b00, 3'(k >> 1), 2'b10, 1'(k)},
                                   8'(rand_bits(8)), (k % 2 == 1) ? 5 : 2));
        end
        end_test("alu_reg_and_acc", e0);

        // memory operands, then one byte opcodes
        e0 = errors;
        for (int k = 0; k < n_mem; k++) begin
            send_instr(gen_instr(fam_mem));
        end
        for (int k = 0; k < 11; k++) begin
            send_instr(build_instr(seg_bcd_op(k), 8'(rand_bits(8)), 1));
        end
        end_test("mem_seg_bcd", e0);

        e0 = errors;
        for (int k = 0; k < n_bad; k++) begin
            send_instr(gen_instr(fam_bad));
        end
        end_test("invalid_forms", e0);

        // mixed stream under random result stalls, some with long tails
        e0 = errors;
        stall_mode = 1'b1;
        for (int k = 0; k < n_random; k++) begin
            instr_t t;
            int     fam;
            fam = int'(rand_bits(3) % 5);
            t   = gen_instr(fam);
            if (fam != fam_bad && rand_bits(2) == 0) begin
                t.len = len_t'(max_instr_bytes);
            end
            send_instr(t);
        end
        end_test("random_backpressure", e0);
        stall_mode = 1'b0;

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+sim
verilog/x86_decode_pkg.sv
verilog/byte_stream_if.sv
verilog/hold_stage.sv
verilog/instr_byte_feeder.sv
verilog/operand_decoder.sv
verilog/x86_decoder.sv
sim/tb_x86_decoder.sv

//--- run_sim.sh
#!/bin/sh
# build and run the x86 decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_x86_decoder -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_x86_decoder)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
